//--- common/gfx_pkg.sv
package gfx_pkg;

  // pixel layout, four bits per channel
  localparam int color_bits = 4;
  localparam int pixel_bits = 3 * color_bits;
  localparam int meta_bits  = 4;

  // framebuffer word holds color above meta
  localparam int word_bits = pixel_bits + meta_bits;

  // horizontal timing in pixels, after the visible span
  localparam int h_front = 2;
  localparam int h_sync  = 3;
  localparam int h_back  = 2;

  // vertical timing in lines, after the visible lines
  localparam int v_front = 1;
  localparam int v_sync  = 2;
  localparam int v_back  = 1;

  // writer holds at most one word waiting for the memory
  typedef enum logic {
    idle,
    pending
  } fbw_state_t;

endpackage

//--- common/fb_write_if.sv
`timescale 1ns/1ps

interface fb_write_if
  import gfx_pkg::*;
#(
  parameter int addr_bits = 7
) ();

  logic [addr_bits-1:0] addr;
  logic [word_bits-1:0] data;
  logic                 valid;
  logic                 ready;

  // transfer on a clock edge with valid and ready both high
  modport writer(output addr, output data, output valid, input ready);
  modport memory(input addr, input data, input valid, output ready);

endinterface

//--- common/fb_read_if.sv
`timescale 1ns/1ps

interface fb_read_if
  import gfx_pkg::*;
#(
  parameter int addr_bits = 7
) ();

  logic [addr_bits-1:0] addr;
  logic                 req;
  logic [word_bits-1:0] data;
  logic                 data_valid;

  // every req is answered one clock later, no back-pressure
  modport reader(output addr, output req, input data, input data_valid);
  modport memory(input addr, input req, output data, output data_valid);

endinterface

//--- fb/fb_writer.sv
`timescale 1ns/1ps

module fb_writer
  import gfx_pkg::*;
#(
  parameter int fb_width  = 16,
  parameter int fb_height = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [$clog2(fb_width):0]            x,
  input  logic [$clog2(fb_height):0]           y,
  input  logic [pixel_bits-1:0]                color,
  input  logic [meta_bits-1:0]                 meta,
  input  logic                                 valid,
  output logic                                 ready,
  fb_write_if.writer                           wr
);

  localparam int addr_bits = $clog2(fb_width * fb_height);

  fbw_state_t                state;
  logic                      in_range;
  logic [addr_bits-1:0]      lin_addr;
  logic [$clog2(fb_width):0] wait_cnt;

  // coordinates carry one spare bit so off-screen points can arrive
  assign in_range = (x < fb_width) && (y < fb_height);
  assign lin_addr = addr_bits'(y * fb_width + x);

  assign ready    = (state == idle);
  assign wr.valid = (state == pending);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      case (state)
        // off-screen requests are accepted and dropped here
        idle:    if (valid && in_range) state <= pending;
        pending: if (wr.ready) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ready && valid && in_range) begin
      wr.addr <= lin_addr;
      wr.data <= {color, meta};
    end
  end

  // clocks the pending word has been held off by display reads
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (wr.valid && !wr.ready) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  // reads come in bursts of at most one visible line so the word waits no longer
  assert property (@(posedge clk) disable iff (!rst_n) wait_cnt <= fb_width);

endmodule

//--- fb/fb_mem.sv
`timescale 1ns/1ps

module fb_mem
  import gfx_pkg::*;
#(
  parameter int fb_width  = 16,
  parameter int fb_height = 8
) (
  input logic        clk,
  input logic        rst_n,
  fb_write_if.memory wr,
  fb_read_if.memory  rd
);

  localparam int depth = fb_width * fb_height;

  logic [word_bits-1:0] mem [depth];

  // the display read always wins the single access per cycle
  assign wr.ready = !rd.req;

  always_ff @(posedge clk) begin
    if (rd.req) begin
      rd.data <= mem[rd.addr];
    end else if (wr.valid) begin
      mem[wr.addr] <= wr.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd.data_valid <= 1'b0;
    end else begin
      rd.data_valid <= rd.req;
    end
  end

  // a stalled write keeps its address and word until it is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    wr.valid && !wr.ready |=> wr.valid && $stable(wr.addr) && $stable(wr.data));

endmodule

//--- rtl/vga_fb_pixel_stream.sv
`timescale 1ns/1ps

module vga_fb_pixel_stream
  import gfx_pkg::*;
#(
  parameter int fb_width  = 16,
  parameter int fb_height = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  fb_read_if.reader             rd,
  output logic                  valid,
  output logic                  hsync,
  output logic                  vsync,
  output logic [color_bits-1:0] red,
  output logic [color_bits-1:0] grn,
  output logic [color_bits-1:0] blu,
  output logic [meta_bits-1:0]  meta
);

  localparam int h_total      = fb_width + h_front + h_sync + h_back;
  localparam int v_total      = fb_height + v_front + v_sync + v_back;
  localparam int h_sync_start = fb_width + h_front;
  localparam int v_sync_start = fb_height + v_front;
  localparam int h_bits       = $clog2(h_total);
  localparam int v_bits       = $clog2(v_total);
  localparam int addr_bits    = $clog2(fb_width * fb_height);

  logic [h_bits-1:0] h_cnt;
  logic [v_bits-1:0] v_cnt;
  logic              visible;
  logic              hs_now;
  logic              vs_now;

  // stage a lines up with the read request, stage b with the memory data
  logic              valid_a;
  logic              blank_a;
  logic              hs_a;
  logic              vs_a;
  logic              valid_b;
  logic              blank_b;
  logic              hs_b;
  logic              vs_b;

  assign visible = (h_cnt < fb_width) && (v_cnt < fb_height);
  assign hs_now  = !((h_cnt >= h_sync_start) && (h_cnt < h_sync_start + h_sync));
  assign vs_now  = !((v_cnt >= v_sync_start) && (v_cnt < v_sync_start + v_sync));

  // raster order is visible, front porch, sync and back porch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (enable) begin
      if (h_cnt == h_bits'(h_total - 1)) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == v_bits'(v_total - 1)) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd.req  <= 1'b0;
      valid_a <= 1'b0;
      blank_a <= 1'b1;
      hs_a    <= 1'b1;
      vs_a    <= 1'b1;
    end else begin
      rd.req  <= enable && visible;
      valid_a <= enable;
      // syncs keep their level while paused
      if (enable) begin
        blank_a <= !visible;
        hs_a    <= hs_now;
        vs_a    <= vs_now;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enable && visible) begin
      rd.addr <= addr_bits'(v_cnt * fb_width + h_cnt);
    end
  end

  // enable only gates new positions and stages already in flight always drain
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_b <= 1'b0;
      blank_b <= 1'b1;
      hs_b    <= 1'b1;
      vs_b    <= 1'b1;
      valid   <= 1'b0;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
    end else begin
      valid_b <= valid_a;
      blank_b <= blank_a;
      hs_b    <= hs_a;
      vs_b    <= vs_a;
      valid   <= valid_b;
      hsync   <= hs_b;
      vsync   <= vs_b;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_b) begin
      {red, grn, blu, meta} <= (rd.data_valid && !blank_b) ? rd.data : '0;
    end
  end

  // an output pixel with hsync low came from a position inside the sync span
  assert property (@(posedge clk) disable iff (!rst_n)
    valid && !hsync |->
      ($past(h_cnt, 3) >= h_sync_start) && ($past(h_cnt, 3) < h_sync_start + h_sync));

endmodule

//--- rtl/cdc_fifo.sv
`timescale 1ns/1ps

module cdc_fifo #(
  parameter int data_bits          = 18,
  parameter int addr_bits          = 4,
  parameter int almost_full_margin = 6
) (
  input  logic                 w_clk,
  input  logic                 rst_n,
  input  logic                 w_inc,
  input  logic [data_bits-1:0] w_data,
  output logic                 w_full,
  output logic                 w_almost_full,
  input  logic                 r_clk,
  output logic [data_bits-1:0] r_data,
  output logic                 r_valid
);

  localparam int depth = 1 << addr_bits;

  logic [data_bits-1:0] mem [depth];

  // pointers carry one extra bit to tell full from empty
  logic [addr_bits:0]   w_bin;
  logic [addr_bits:0]   w_bin_next;
  logic [addr_bits:0]   w_gray;
  logic [addr_bits:0]   wq1_r_gray;
  logic [addr_bits:0]   wq2_r_gray;
  logic [addr_bits:0]   w_used;
  logic                 w_push;
  logic [addr_bits:0]   r_bin;
  logic [addr_bits:0]   r_bin_next;
  logic [addr_bits:0]   r_gray;
  logic [addr_bits:0]   rq1_w_gray;
  logic [addr_bits:0]   rq2_w_gray;
  logic                 r_empty;

  function automatic logic [addr_bits:0] bin2gray(input logic [addr_bits:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [addr_bits:0] gray2bin(input logic [addr_bits:0] g);
    logic [addr_bits:0] b;
    b[addr_bits] = g[addr_bits];
    for (int i = addr_bits - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // write domain
  assign w_full = (w_gray == {~wq2_r_gray[addr_bits:addr_bits-1],
                              wq2_r_gray[addr_bits-2:0]});
  assign w_push        = w_inc && !w_full;
  assign w_bin_next    = w_bin + (addr_bits + 1)'(w_push);
  assign w_used        = w_bin - gray2bin(wq2_r_gray);
  // pessimistic, the read pointer seen here is a few clocks old
  assign w_almost_full = (depth - w_used) <= almost_full_margin;

  always_ff @(posedge w_clk) begin
    if (w_push) begin
      mem[w_bin[addr_bits-1:0]] <= w_data;
    end
  end

  always_ff @(posedge w_clk or negedge rst_n) begin
    if (!rst_n) begin
      w_bin      <= '0;
      w_gray     <= '0;
      wq1_r_gray <= '0;
      wq2_r_gray <= '0;
    end else begin
      w_bin      <= w_bin_next;
      w_gray     <= bin2gray(w_bin_next);
      wq1_r_gray <= r_gray;
      wq2_r_gray <= wq1_r_gray;
    end
  end

  // read domain pops whenever something is there
  assign r_empty    = (r_gray == rq2_w_gray);
  assign r_bin_next = r_bin + (addr_bits + 1)'(!r_empty);

  always_ff @(posedge r_clk or negedge rst_n) begin
    if (!rst_n) begin
      r_bin      <= '0;
      r_gray     <= '0;
      rq1_w_gray <= '0;
      rq2_w_gray <= '0;
      r_valid    <= 1'b0;
      r_data     <= '0;
    end else begin
      r_bin      <= r_bin_next;
      r_gray     <= bin2gray(r_bin_next);
      rq1_w_gray <= w_gray;
      rq2_w_gray <= rq1_w_gray;
      r_valid    <= !r_empty;
      if (!r_empty) begin
        r_data <= mem[r_bin[addr_bits-1:0]];
      end
    end
  end

  // the almost-full throttle upstream must keep us from ever filling up
  assert property (@(posedge w_clk) disable iff (!rst_n) !(w_inc && w_full));

endmodule

//--- rtl/gfx_vga.sv
`timescale 1ns/1ps

module gfx_vga
  import gfx_pkg::*;
#(
  parameter int fb_width           = 16,
  parameter int fb_height          = 8,
  parameter int fifo_addr_bits     = 4,
  parameter int almost_full_margin = 6
) (
  input  logic                       clk,
  input  logic                       pixel_clk,
  input  logic                       rst_n,

  // drawing side
  input  logic [$clog2(fb_width):0]  gfx_x,
  input  logic [$clog2(fb_height):0] gfx_y,
  input  logic [pixel_bits-1:0]      gfx_color,
  input  logic [meta_bits-1:0]       gfx_meta,
  input  logic                       gfx_valid,
  output logic                       gfx_ready,
  output logic                       gfx_vsync,

  // display side
  input  logic                       vga_enable,
  output logic [color_bits-1:0]      vga_red,
  output logic [color_bits-1:0]      vga_grn,
  output logic [color_bits-1:0]      vga_blu,
  output logic [meta_bits-1:0]       vga_meta,
  output logic                       vga_hsync,
  output logic                       vga_vsync,
  output logic                       vga_valid
);

  localparam int addr_bits = $clog2(fb_width * fb_height);
  localparam int fifo_bits = pixel_bits + meta_bits + 2;

  logic                  st_valid;
  logic                  st_hsync;
  logic                  st_vsync;
  logic [color_bits-1:0] st_red;
  logic [color_bits-1:0] st_grn;
  logic [color_bits-1:0] st_blu;
  logic [meta_bits-1:0]  st_meta;
  logic                  fifo_almost_full;
  logic [fifo_bits-1:0]  fifo_w_data;
  logic [fifo_bits-1:0]  fifo_r_data;

  fb_write_if #(.addr_bits(addr_bits)) fb_wr ();
  fb_read_if #(.addr_bits(addr_bits)) fb_rd ();

  fb_writer #(
    .fb_width (fb_width),
    .fb_height(fb_height)
  ) i_fb_writer (
    .clk  (clk),
    .rst_n(rst_n),
    .x    (gfx_x),
    .y    (gfx_y),
    .color(gfx_color),
    .meta (gfx_meta),
    .valid(gfx_valid),
    .ready(gfx_ready),
    .wr   (fb_wr.writer)
  );

  fb_mem #(
    .fb_width (fb_width),
    .fb_height(fb_height)
  ) i_fb_mem (
    .clk  (clk),
    .rst_n(rst_n),
    .wr   (fb_wr.memory),
    .rd   (fb_rd.memory)
  );

  vga_fb_pixel_stream #(
    .fb_width (fb_width),
    .fb_height(fb_height)
  ) i_stream (
    .clk   (clk),
    .rst_n (rst_n),
    .enable(vga_enable && !fifo_almost_full),
    .rd    (fb_rd.reader),
    .valid (st_valid),
    .hsync (st_hsync),
    .vsync (st_vsync),
    .red   (st_red),
    .grn   (st_grn),
    .blu   (st_blu),
    .meta  (st_meta)
  );

  // drawing client can use it to pace frame updates
  assign gfx_vsync = st_vsync;

  // syncs cross inverted so the fifo's cleared output reads as inactive
  assign fifo_w_data = {~st_hsync, ~st_vsync, st_red, st_grn, st_blu, st_meta};
  assign {vga_hsync, vga_vsync} = ~fifo_r_data[fifo_bits-1:fifo_bits-2];
  assign {vga_red, vga_grn, vga_blu, vga_meta} = fifo_r_data[fifo_bits-3:0];

  // full is never reached while the stream is throttled by almost-full
  cdc_fifo #(
    .data_bits         (fifo_bits),
    .addr_bits         (fifo_addr_bits),
    .almost_full_margin(almost_full_margin)
  ) i_cdc_fifo (
    .w_clk        (clk),
    .rst_n        (rst_n),
    .w_inc        (st_valid),
    .w_data       (fifo_w_data),
    .w_full       (),
    .w_almost_full(fifo_almost_full),
    .r_clk        (pixel_clk),
    .r_data       (fifo_r_data),
    .r_valid      (vga_valid)
  );

endmodule

//--- test/tb_gfx_vga.sv
`timescale 1ns/1ps

module tb_gfx_vga
  import gfx_pkg::*;
();

  localparam int fb_width     = 16;
  localparam int fb_height    = 8;
  localparam int x_bits       = $clog2(fb_width) + 1;
  localparam int y_bits       = $clog2(fb_height) + 1;
  localparam int depth        = fb_width * fb_height;
  localparam int h_total      = fb_width + h_front + h_sync + h_back;
  localparam int v_total      = fb_height + v_front + v_sync + v_back;
  localparam int hs_start     = fb_width + h_front;
  localparam int vs_start     = fb_height + v_front;
  localparam int clk_ns       = 8;
  localparam int pclk_ns      = 20;
  localparam int write_limit  = 64;
  localparam int n_random     = 40;
  localparam int n_paused     = 8;
  localparam int pause_cycles = 400;
  // the tests wait on about 21 output frames in total, doubled for margin
  localparam int frame_ns     = h_total * v_total * pclk_ns;
  localparam int write_ns     = (depth + n_random + n_paused) * 2 * write_limit * clk_ns;
  localparam int watchdog_ns  = 2 * (24 * frame_ns + write_ns + pause_cycles * clk_ns);

  logic                   clk;
  logic                   pixel_clk;
  logic                   rst_n;
  logic [x_bits-1:0]      gfx_x;
  logic [y_bits-1:0]      gfx_y;
  logic [pixel_bits-1:0]  gfx_color;
  logic [meta_bits-1:0]   gfx_meta;
  logic                   gfx_valid;
  logic                   gfx_ready;
  logic                   gfx_vsync;
  logic                   vga_enable;
  logic [color_bits-1:0]  vga_red;
  logic [color_bits-1:0]  vga_grn;
  logic [color_bits-1:0]  vga_blu;
  logic [meta_bits-1:0]   vga_meta;
  logic                   vga_hsync;
  logic                   vga_vsync;
  logic                   vga_valid;

  // mirror of the framebuffer contents
  logic [word_bits-1:0]   model [depth];
  logic [31:0]            rng = 32'ha56e8a23;
  int                     errors = 0;
  int                     pix_checks = 0;

  // output monitor state
  bit  locked = 1'b0;
  bit  prev_vs = 1'b1;
  bit  prev_hs = 1'b1;
  bit  line_seen = 1'b0;
  bit  chk_on = 1'b0;
  int  chk_from = 0;
  int  mon_h = 0;
  int  mon_v = 0;
  int  frame_idx = 0;
  int  vs_falls = 0;
  int  line_len = 0;
  int  hs_run = 0;
  int  fr_samples, fr_hs_low, fr_hs_falls, fr_vs_low;
  int  last_samples, last_hs_low, last_hs_falls, last_vs_low;
  int  gv_falls = 0;
  bit  prev_gv = 1'b1;

  gfx_vga #(
    .fb_width          (fb_width),
    .fb_height         (fb_height),
    .fifo_addr_bits    (4),
    .almost_full_margin(6)
  ) i_dut (
    .clk       (clk),
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_meta  (gfx_meta),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .gfx_vsync (gfx_vsync),
    .vga_enable(vga_enable),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_meta  (vga_meta),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_valid (vga_valid)
  );

  always #(clk_ns / 2) clk = ~clk;
  always #(pclk_ns / 2) pixel_clk = ~pixel_clk;

  function automatic logic [31:0] xorshift_next(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // odd multiplier keeps every address distinct
  function automatic logic [word_bits-1:0] fill_word(input int addr);
    return word_bits'(addr * 16'h0193) ^ 16'h5a3c;
  endfunction

  task automatic report_mismatch(input string name, input int expected, input int actual);
    errors++;
    $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
  endtask

  task automatic compare_sample();
    logic [word_bits-1:0] word;
    logic                 exp_hs;
    logic                 exp_vs;
    int                   a;
    word   = {vga_red, vga_grn, vga_blu, vga_meta};
    exp_hs = !(mon_h >= hs_start && mon_h < hs_start + h_sync);
    exp_vs = !(mon_v >= vs_start && mon_v < vs_start + v_sync);
    if (vga_hsync !== exp_hs)
      report_mismatch($sformatf("vga_hsync (%0d,%0d)", mon_h, mon_v), exp_hs, vga_hsync);
    if (vga_vsync !== exp_vs)
      report_mismatch($sformatf("vga_vsync (%0d,%0d)", mon_h, mon_v), exp_vs, vga_vsync);
    if (mon_h < fb_width && mon_v < fb_height) begin
      if (chk_on && frame_idx >= chk_from) begin
        a = mon_v * fb_width + mon_h;
        pix_checks++;
        if (word !== model[a])
          report_mismatch($sformatf("vga pixel (%0d,%0d)", mon_h, mon_v), model[a], word);
      end
    end else if (word !== '0) begin
      report_mismatch($sformatf("vga blanking (%0d,%0d)", mon_h, mon_v), 0, word);
    end
  endtask

  task automatic count_sync();
    if (prev_vs && !vga_vsync) begin
      if (vs_falls > 0) begin
        last_samples  = fr_samples;
        last_hs_low   = fr_hs_low;
        last_hs_falls = fr_hs_falls;
        last_vs_low   = fr_vs_low;
      end
      vs_falls++;
      fr_samples  = 0;
      fr_hs_low   = 0;
      fr_hs_falls = 0;
      fr_vs_low   = 0;
    end
    fr_samples++;
    if (!vga_hsync) fr_hs_low++;
    if (!vga_vsync) fr_vs_low++;
    if (prev_hs && !vga_hsync) begin
      fr_hs_falls++;
      if (line_seen && line_len != h_total)
        report_mismatch("samples per line", h_total, line_len);
      line_seen = 1'b1;
      line_len  = 0;
    end
    line_len++;
    if (!vga_hsync) begin
      hs_run++;
    end else begin
      if (!prev_hs && hs_run != h_sync)
        report_mismatch("vga_hsync low samples", h_sync, hs_run);
      hs_run = 0;
    end
  endtask

  // raster position of each output sample, locked at the first vsync fall
  always @(negedge pixel_clk) begin
    if (rst_n && vga_valid) begin
      if (locked) begin
        if (mon_h == h_total - 1) begin
          mon_h = 0;
          mon_v = (mon_v == v_total - 1) ? 0 : mon_v + 1;
          if (mon_v == 0) frame_idx++;
        end else begin
          mon_h++;
        end
      end else if (prev_vs && !vga_vsync) begin
        locked = 1'b1;
        mon_h  = 0;
        mon_v  = vs_start;
        hs_run = 0;
      end
      if (locked) begin
        compare_sample();
        count_sync();
      end
      prev_vs = vga_vsync;
      prev_hs = vga_hsync;
    end
  end

  // vsync pulses as the drawing side sees them
  always @(negedge clk) begin
    if (rst_n) begin
      if (prev_gv && !gfx_vsync) gv_falls++;
      prev_gv = gfx_vsync;
    end
  end

  task automatic draw_pixel(input int x, input int y, input logic [pixel_bits-1:0] color,
                            input logic [meta_bits-1:0] meta);
    int waited;
    @(posedge clk);
    gfx_x     <= x_bits'(x);
    gfx_y     <= y_bits'(y);
    gfx_color <= color;
    gfx_meta  <= meta;
    gfx_valid <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!gfx_ready && waited < write_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!gfx_ready) begin
      errors++;
      $display("ERROR at %0t ns: drawing request at (%0d,%0d) was not accepted", $time, x, y);
    end
    @(posedge clk);
    gfx_valid <= 1'b0;
    // ready comes back once the memory has taken the word
    waited = 0;
    @(negedge clk);
    while (!gfx_ready && waited < write_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!gfx_ready) begin
      errors++;
      $display("ERROR at %0t ns: drawing write at (%0d,%0d) never completed", $time, x, y);
    end
    if (x < fb_width && y < fb_height) model[y * fb_width + x] = {color, meta};
  endtask

  task automatic pixel_check_off();
    chk_on = 1'b0;
  endtask

  // the stream is at most one frame ahead of the output
  task automatic pixel_check_from_next();
    chk_from = frame_idx + 2;
    chk_on   = 1'b1;
  endtask

  task automatic wait_checked_frame();
    int c0;
    c0 = pix_checks;
    while (frame_idx < chk_from + 1) @(negedge pixel_clk);
    if (pix_checks - c0 < depth) begin
      errors++;
      $display("ERROR at %0t ns: only %0d visible pixels were compared in a frame",
               $time, pix_checks - c0);
    end
  endtask

  task automatic verify_reset_state();
    int waited;
    @(negedge clk);
    if (gfx_ready !== 1'b1) report_mismatch("gfx_ready", 1, gfx_ready);
    if (gfx_vsync !== 1'b1) report_mismatch("gfx_vsync", 1, gfx_vsync);
    if (vga_hsync !== 1'b1) report_mismatch("vga_hsync", 1, vga_hsync);
    if (vga_vsync !== 1'b1) report_mismatch("vga_vsync", 1, vga_vsync);
    repeat (20) begin
      @(negedge pixel_clk);
      if (vga_valid !== 1'b0) report_mismatch("vga_valid", 0, vga_valid);
    end
    @(posedge clk);
    vga_enable <= 1'b1;
    waited = 0;
    while (vga_valid !== 1'b1 && waited < 50) begin
      @(negedge pixel_clk);
      waited++;
    end
    if (vga_valid !== 1'b1) begin
      errors++;
      $display("ERROR at %0t ns: no pixel reached the display output after enable", $time);
    end
  endtask

  task automatic fill_framebuffer();
    logic [word_bits-1:0] w;
    pixel_check_off();
    for (int a = 0; a < depth; a++) begin
      w = fill_word(a);
      draw_pixel(a % fb_width, a / fb_width, w[word_bits-1:meta_bits], w[meta_bits-1:0]);
    end
    pixel_check_from_next();
    wait_checked_frame();
  endtask

  task automatic measure_frame_timing();
    int n0;
    n0 = vs_falls;
    while (vs_falls <= n0 || vs_falls < 2) @(negedge pixel_clk);
    if (last_samples != h_total * v_total)
      report_mismatch("samples per frame", h_total * v_total, last_samples);
    if (last_hs_falls != v_total)
      report_mismatch("lines per frame", v_total, last_hs_falls);
    if (last_hs_low != h_sync * v_total)
      report_mismatch("vga_hsync low samples per frame", h_sync * v_total, last_hs_low);
    if (last_vs_low != v_sync * h_total)
      report_mismatch("vga_vsync low samples per frame", v_sync * h_total, last_vs_low);
  endtask

  task automatic random_overwrites();
    logic [31:0] r;
    int          x;
    int          y;
    pixel_check_off();
    for (int i = 0; i < n_random; i++) begin
      rng = xorshift_next(rng);
      r   = rng;
      x   = int'(r[11:4]) % fb_width;
      y   = int'(r[19:12]) % fb_height;
      // about one in four lands off screen
      if (r[31:30] == 2'b00) begin
        if (r[29]) x = fb_width + int'(r[3:0]) % fb_width;
        else y = fb_height + int'(r[22:20]) % fb_height;
      end
      rng = xorshift_next(rng);
      draw_pixel(x, y, rng[pixel_bits-1:0], rng[pixel_bits+meta_bits-1:pixel_bits]);
    end
    pixel_check_from_next();
    wait_checked_frame();
  endtask

  task automatic pause_display();
    int n0;
    while (!(locked && mon_v == fb_height / 2)) @(negedge pixel_clk);
    n0 = vs_falls;
    pixel_check_off();
    @(posedge clk);
    vga_enable <= 1'b0;
    // reads are stopped, so these must not stall
    for (int i = 0; i < n_paused; i++) begin
      rng = xorshift_next(rng);
      draw_pixel(int'(rng[7:0]) % fb_width, int'(rng[15:8]) % fb_height,
                 rng[27:16], rng[31:28]);
    end
    repeat (pause_cycles) @(posedge clk);
    vga_enable <= 1'b1;
    while (vs_falls <= n0) @(negedge pixel_clk);
    if (last_samples != h_total * v_total)
      report_mismatch("samples in the paused frame", h_total * v_total, last_samples);
    pixel_check_from_next();
    wait_checked_frame();
  endtask

  task automatic count_gfx_vsync();
    int g0;
    int n0;
    g0 = gv_falls;
    while (gv_falls == g0) @(negedge clk);
    g0 = gv_falls - 1;
    n0 = vs_falls;
    // two output frames pass while the drawing side sees two pulses
    while (vs_falls < n0 + 2) @(negedge pixel_clk);
    if (gv_falls - g0 != 2) report_mismatch("gfx_vsync falls over two frames", 2, gv_falls - g0);
  endtask

  initial begin
    clk        = 1'b0;
    pixel_clk  = 1'b0;
    rst_n      = 1'b0;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_color  = '0;
    gfx_meta   = '0;
    gfx_valid  = 1'b0;
    vga_enable = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    verify_reset_state();
    fill_framebuffer();
    measure_frame_timing();
    random_overwrites();
    pause_display();
    count_gfx_vsync();
    $display("tb_gfx_vga: %0d pixel checks, %0d errors", pix_checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("ERROR at %0t ns: watchdog expired before the tests finished", $time);
    $display("tb_gfx_vga: %0d pixel checks, %0d errors", pix_checks, errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- all.f
common/gfx_pkg.sv
common/fb_write_if.sv
common/fb_read_if.sv
fb/fb_writer.sv
fb/fb_mem.sv
rtl/vga_fb_pixel_stream.sv
rtl/cdc_fifo.sv
rtl/gfx_vga.sv
test/tb_gfx_vga.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_gfx_vga -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/Vtb_gfx_vga)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

printf '%s\n' "$out" | grep -qxF '** PASS **'
exit $?
